// ==== sim.f ====
+incdir+source
source/bus_monitor_pkg.sv
source/uart_line_rx.sv
source/tl_write_snoop.sv
source/tl_traffic_stats.sv
source/bus_monitor_top.sv
tests/bus_monitor_asserts.sv
tests/bus_monitor_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide pass or fail from its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sim.f --top-module bus_monitor_tb \
  || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vbus_monitor_tb +verilator+error+limit+1000 2>&1) ; echo "$sim_out"

grep -qx "all tests passed" <<< "$sim_out" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tests/bus_monitor_tb.sv ====
`timescale 1ns/1ps
`include "bus_monitor_macros.svh"

module bus_monitor_tb;

  localparam int clk_period = 40;
  localparam int bit_ticks  = `UART_BIT_TICKS;
  localparam int n_bytes    = 10;
  localparam int bus_cycles = 300;
  // Twice the time of all serial frames, the glitch, the gaps and the bus phase
  localparam longint timeout_ns =
    longint'((n_bytes + 4) * 10 * bit_ticks + bus_cycles + 50) * clk_period * 2;

  localparam bus_monitor_pkg::tl_addr_t wdata_addr = `UART_BASE + `UART_WDATA_OFF;
  localparam bus_monitor_pkg::tl_addr_t ctrl_addr  = `UART_BASE + `UART_CTRL_OFF;

  logic                          clk;
  logic                          rst_n;
  bus_monitor_pkg::tl_req_obs_t  tl_req;
  bus_monitor_pkg::tl_rsp_obs_t  tl_rsp;
  logic                          serial_in;
  logic                          rx_valid;
  bus_monitor_pkg::uart_byte_t   rx_byte;
  logic                          console_valid;
  bus_monitor_pkg::uart_byte_t   console_byte;
  logic                          ctrl_write;
  logic                          tx_enable;
  bus_monitor_pkg::event_count_t req_count;
  bus_monitor_pkg::event_count_t err_count;

  logic [31:0]                 lfsr_state;
  bus_monitor_pkg::uart_byte_t expected_q[$];
  int                          errors;
  int                          rx_seen;

  bus_monitor_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .tl_req        (tl_req),
    .tl_rsp        (tl_rsp),
    .serial_in     (serial_in),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .console_valid (console_valid),
    .console_byte  (console_byte),
    .ctrl_write    (ctrl_write),
    .tx_enable     (tx_enable),
    .req_count     (req_count),
    .err_count     (err_count)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic bus_monitor_pkg::tl_req_obs_t make_req(
    input logic valid, input logic ready, input bus_monitor_pkg::tl_opcode_e op,
    input bus_monitor_pkg::tl_addr_t addr, input bus_monitor_pkg::tl_data_t data);
    bus_monitor_pkg::tl_req_obs_t req;
    req.a_valid   = valid;
    req.a_ready   = ready;
    req.a_opcode  = op;
    req.a_address = addr;
    req.a_data    = data;
    return req;
  endfunction

  task automatic drive_cycle(input bus_monitor_pkg::tl_req_obs_t req,
                             input bus_monitor_pkg::tl_rsp_obs_t rsp);
    @(posedge clk);
    tl_req <= req;
    tl_rsp <= rsp;
  endtask

  task automatic random_bus(input int cycles);
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    bus_monitor_pkg::tl_rsp_obs_t rsp;
    for (int i = 0; i < cycles; i++) begin
      take_bits(2, r);
      case (r[1:0])
        2'd0: addr = wdata_addr;
        2'd1: addr = ctrl_addr;
        2'd2: begin
          take_bits(6, r);
          addr = `UART_BASE + {26'd0, r[5:0]};
        end
        default: take_bits(32, addr);
      endcase
      take_bits(32, data);
      take_bits(7, r);
      rsp.d_valid = r[5];
      rsp.d_error = r[6];
      drive_cycle(make_req(r[0], r[1], bus_monitor_pkg::tl_opcode_e'(r[4:2]), addr, data), rsp);
    end
  endtask

  // Called on a rising edge and sends the LSB first with one stop bit
  task automatic send_frame(input bus_monitor_pkg::uart_byte_t b, input logic expect_rx);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    if (expect_rx) begin
      expected_q.push_back(b);
    end
    for (int i = 0; i < 10; i++) begin
      serial_in <= frame[i];
      repeat (bit_ticks) @(posedge clk);
    end
  endtask

  // --------------------------------------------------
  // Received byte checks
  // --------------------------------------------------
  always @(posedge clk) begin
    bus_monitor_pkg::uart_byte_t exp_b;
    if (rst_n && rx_valid) begin
      if (expected_q.size() == 0) begin
        errors++;
        $display("Unexpected rx_valid at t=%0t with no byte in flight", $time);
      end else begin
        exp_b = expected_q.pop_front();
        rx_seen++;
        if (rx_byte !== exp_b) begin
          errors++;
          $display("FAIL t=%0t rx_byte expected 8'h%02h actual 8'h%02h", $time, exp_b, rx_byte);
        end
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("Watchdog expired before the run reached its end");
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    rst_n      = 1'b0;
    tl_req     = '0;
    tl_rsp     = '0;
    serial_in  = 1'b1;
    lfsr_state = 32'h16482a00;
    errors     = 0;
    rx_seen    = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Directed writes followed by random bus traffic
    drive_cycle(make_req(1'b1, 1'b1, bus_monitor_pkg::PUT_FULL_DATA, wdata_addr, 32'h1241), '0);
    drive_cycle(make_req(1'b1, 1'b1, bus_monitor_pkg::PUT_PARTIAL_DATA, wdata_addr,
                         32'h5a5a_a5c3), 2'b11);
    drive_cycle(make_req(1'b1, 1'b1, bus_monitor_pkg::GET, wdata_addr, 32'h77), '0);
    drive_cycle(make_req(1'b1, 1'b0, bus_monitor_pkg::PUT_FULL_DATA, wdata_addr, 32'h88), 2'b01);
    drive_cycle(make_req(1'b1, 1'b1, bus_monitor_pkg::PUT_FULL_DATA, wdata_addr + 4, 32'h99), '0);
    drive_cycle(make_req(1'b1, 1'b1, bus_monitor_pkg::PUT_FULL_DATA, ctrl_addr, 32'h1), '0);
    drive_cycle(make_req(1'b1, 1'b1, bus_monitor_pkg::PUT_PARTIAL_DATA, ctrl_addr,
                         32'hffff_fffe), 2'b11);
    random_bus(bus_cycles);
    drive_cycle(make_req(1'b1, 1'b1, bus_monitor_pkg::PUT_FULL_DATA, ctrl_addr, 32'h1), '0);
    drive_cycle('0, '0);
    @(posedge clk);

    // Short low pulse must not start a frame
    serial_in <= 1'b0;
    repeat (bit_ticks / 4) @(posedge clk);
    serial_in <= 1'b1;
    repeat (2 * bit_ticks) @(posedge clk);

    for (int i = 0; i < n_bytes; i++) begin
      take_bits(8, r);
      send_frame(r[7:0], 1'b1);
    end

    // Receiver disarmed
    drive_cycle(make_req(1'b1, 1'b1, bus_monitor_pkg::PUT_FULL_DATA, ctrl_addr, 32'h0), '0);
    drive_cycle('0, '0);
    send_frame(8'h3c, 1'b0);
    repeat (2 * bit_ticks) @(posedge clk);

    while (expected_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);

    $display("Summary: %0d check errors, %0d assertion failures, %0d bytes received",
             errors, dut0.u_asserts.fail_count, rx_seen);
    if (errors == 0 && dut0.u_asserts.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tests/bus_monitor_asserts.sv ====
`timescale 1ns/1ps
`include "bus_monitor_macros.svh"

module bus_monitor_asserts (
  input logic                          clk,
  input logic                          rst_n,
  input bus_monitor_pkg::tl_req_obs_t  tl_req,
  input bus_monitor_pkg::tl_rsp_obs_t  tl_rsp,
  input logic                          console_valid,
  input bus_monitor_pkg::uart_byte_t   console_byte,
  input logic                          ctrl_write,
  input logic                          tx_enable,
  input bus_monitor_pkg::event_count_t req_count,
  input bus_monitor_pkg::event_count_t err_count
);

  int fail_count = 0;

  logic accepted;
  logic put_op;
  logic wdata_put;
  logic ctrl_put;
  logic err_rsp;

  assign accepted  = tl_req.a_valid && tl_req.a_ready;
  assign put_op    = (tl_req.a_opcode == bus_monitor_pkg::PUT_FULL_DATA) ||
                     (tl_req.a_opcode == bus_monitor_pkg::PUT_PARTIAL_DATA);
  assign wdata_put = accepted && put_op &&
                     (tl_req.a_address == `UART_BASE + `UART_WDATA_OFF);
  assign ctrl_put  = accepted && put_op &&
                     (tl_req.a_address == `UART_BASE + `UART_CTRL_OFF);
  assign err_rsp   = tl_rsp.d_valid && tl_rsp.d_error;

  // --------------------------------------------------
  // Register write decode
  // --------------------------------------------------
  console_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    wdata_put |=> console_valid && (console_byte == $past(tl_req.a_data[7:0])))
  else begin
    fail_count++;
    $error("console_valid or console_byte wrong after a WDATA write");
  end

  console_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !wdata_put |=> !console_valid)
  else begin
    fail_count++;
    $error("console_valid without a WDATA write");
  end

  ctrl_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_put |=> ctrl_write && (tx_enable == $past(tl_req.a_data[0])))
  else begin
    fail_count++;
    $error("ctrl_write or tx_enable wrong after a CTRL write");
  end

  ctrl_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !ctrl_put |=> !ctrl_write && $stable(tx_enable))
  else begin
    fail_count++;
    $error("ctrl_write or tx_enable moved without a CTRL write");
  end

  // --------------------------------------------------
  // Traffic counters
  // --------------------------------------------------
  req_step: assert property (@(posedge clk) disable iff (!rst_n)
    accepted |=> req_count == bus_monitor_pkg::event_count_t'($past(req_count) + 1'b1))
  else begin
    fail_count++;
    $error("req_count did not step after an accepted request");
  end

  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !accepted |=> $stable(req_count))
  else begin
    fail_count++;
    $error("req_count changed with no accepted request");
  end

  err_step: assert property (@(posedge clk) disable iff (!rst_n)
    err_rsp |=> err_count == bus_monitor_pkg::event_count_t'($past(err_count) + 1'b1))
  else begin
    fail_count++;
    $error("err_count did not step after an error response");
  end

  err_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !err_rsp |=> $stable(err_count))
  else begin
    fail_count++;
    $error("err_count changed with no error response");
  end

  // Everything cleared while in reset
  reset_state: assert property (@(posedge clk)
    !rst_n |-> !console_valid && !ctrl_write && !tx_enable && (req_count == '0) &&
               (err_count == '0))
  else begin
    fail_count++;
    $error("Outputs not cleared during reset");
  end

endmodule

bind bus_monitor_top bus_monitor_asserts u_asserts (
  .clk           (clk),
  .rst_n         (rst_n),
  .tl_req        (tl_req),
  .tl_rsp        (tl_rsp),
  .console_valid (console_valid),
  .console_byte  (console_byte),
  .ctrl_write    (ctrl_write),
  .tx_enable     (tx_enable),
  .req_count     (req_count),
  .err_count     (err_count)
);

// ==== source/bus_monitor_top.sv ====
`timescale 1ns/1ps

module bus_monitor_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  bus_monitor_pkg::tl_req_obs_t  tl_req,
  input  bus_monitor_pkg::tl_rsp_obs_t  tl_rsp,
  input  logic                          serial_in,
  output logic                          rx_valid,
  output bus_monitor_pkg::uart_byte_t   rx_byte,
  output logic                          console_valid,
  output bus_monitor_pkg::uart_byte_t   console_byte,
  output logic                          ctrl_write,
  output logic                          tx_enable,
  output bus_monitor_pkg::event_count_t req_count,
  output bus_monitor_pkg::event_count_t err_count
);

  // --------------------------------------------------
  // Register write decode
  // --------------------------------------------------
  tl_write_snoop u_snoop (
    .clk           (clk),
    .rst_n         (rst_n),
    .tl_req        (tl_req),
    .console_valid (console_valid),
    .console_byte  (console_byte),
    .ctrl_write    (ctrl_write),
    .tx_enable     (tx_enable)
  );

  // --------------------------------------------------
  // Serial line, gated by the tracked TX enable
  // --------------------------------------------------
  uart_line_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (tx_enable),
    .serial_in (serial_in),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte)
  );

  // Bus traffic statistics
  tl_traffic_stats u_stats (
    .clk       (clk),
    .rst_n     (rst_n),
    .tl_req    (tl_req),
    .tl_rsp    (tl_rsp),
    .req_count (req_count),
    .err_count (err_count)
  );

endmodule

// ==== source/tl_traffic_stats.sv ====
`timescale 1ns/1ps

module tl_traffic_stats (
  input  logic                          clk,
  input  logic                          rst_n,
  input  bus_monitor_pkg::tl_req_obs_t  tl_req,
  input  bus_monitor_pkg::tl_rsp_obs_t  tl_rsp,
  output bus_monitor_pkg::event_count_t req_count,
  output bus_monitor_pkg::event_count_t err_count
);

  logic req_fire;
  logic err_fire;

  // Handshake on A, error beat on D
  assign req_fire = tl_req.a_valid && tl_req.a_ready;
  assign err_fire = tl_rsp.d_valid && tl_rsp.d_error;

  // --------------------------------------------------
  // Wrapping counters
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_count <= '0;
    end else if (req_fire) begin
      req_count <= req_count + 1'b1;
    end
  end

  // Independent of the request side, both may step in one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_count <= '0;
    end else if (err_fire) begin
      err_count <= err_count + 1'b1;
    end
  end

endmodule

// ==== source/tl_write_snoop.sv ====
`timescale 1ns/1ps
`include "bus_monitor_macros.svh"

module tl_write_snoop (
  input  logic                         clk,
  input  logic                         rst_n,
  input  bus_monitor_pkg::tl_req_obs_t tl_req,
  output logic                         console_valid,
  output bus_monitor_pkg::uart_byte_t  console_byte,
  output logic                         ctrl_write,
  output logic                         tx_enable
);

  localparam bus_monitor_pkg::tl_addr_t wdata_addr = `UART_BASE + `UART_WDATA_OFF;
  localparam bus_monitor_pkg::tl_addr_t ctrl_addr  = `UART_BASE + `UART_CTRL_OFF;

  logic accepted;
  logic is_put;
  logic wdata_hit;
  logic ctrl_hit;

  // --------------------------------------------------
  // Request qualification
  // --------------------------------------------------
  assign accepted = tl_req.a_valid && tl_req.a_ready;

  // Both put flavours count as register writes
  assign is_put = (tl_req.a_opcode == bus_monitor_pkg::PUT_FULL_DATA) ||
                  (tl_req.a_opcode == bus_monitor_pkg::PUT_PARTIAL_DATA);

  assign wdata_hit = accepted && is_put && (tl_req.a_address == wdata_addr);
  assign ctrl_hit  = accepted && is_put && (tl_req.a_address == ctrl_addr);

  // --------------------------------------------------
  // Strobes and the tracked TX enable
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      console_valid <= 1'b0;
      ctrl_write    <= 1'b0;
      tx_enable     <= 1'b0;
    end else begin
      console_valid <= wdata_hit;
      ctrl_write    <= ctrl_hit;
      // CTRL.TX is bit 0
      if (ctrl_hit) begin
        tx_enable <= tl_req.a_data[0];
      end
    end
  end

  // Console character, low byte of WDATA
  always_ff @(posedge clk) begin
    if (wdata_hit) begin
      console_byte <= tl_req.a_data[7:0];
    end
  end

endmodule

// ==== source/uart_line_rx.sv ====
`timescale 1ns/1ps
`include "bus_monitor_macros.svh"

module uart_line_rx #(
  parameter int bit_ticks = `UART_BIT_TICKS
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        enable,
  input  logic                        serial_in,
  output logic                        rx_valid,
  output bus_monitor_pkg::uart_byte_t rx_byte
);

  // Counter must reach a full bit period
  localparam int cnt_w = $clog2(bit_ticks + 1);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(bit_ticks);
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'(bit_ticks / 2);

  bus_monitor_pkg::uart_rx_state_e state;
  logic [cnt_w-1:0]                tick_cnt;
  logic [2:0]                      bit_idx;
  bus_monitor_pkg::uart_byte_t     shift_q;

  logic sample_data;

  // Middle of a data bit
  assign sample_data = (state == bus_monitor_pkg::RX_DATA) && (tick_cnt == full_cnt);

  // --------------------------------------------------
  // Frame sequencing
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= bus_monitor_pkg::RX_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        bus_monitor_pkg::RX_IDLE: begin
          // Armed only while the transmitter is enabled
          if (enable && !serial_in) begin
            state    <= bus_monitor_pkg::RX_START;
            tick_cnt <= cnt_w'(1);
          end
        end
        bus_monitor_pkg::RX_START: begin
          tick_cnt <= tick_cnt + 1'b1;
          if (tick_cnt == half_cnt) begin
            if (!serial_in) begin
              state    <= bus_monitor_pkg::RX_DATA;
              tick_cnt <= cnt_w'(1);
              bit_idx  <= '0;
            end else begin
              // Glitch, line went back high before mid start bit
              state <= bus_monitor_pkg::RX_IDLE;
            end
          end
        end
        bus_monitor_pkg::RX_DATA: begin
          tick_cnt <= tick_cnt + 1'b1;
          if (sample_data) begin
            tick_cnt <= cnt_w'(1);
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= bus_monitor_pkg::RX_STOP;
            end
          end
        end
        bus_monitor_pkg::RX_STOP: begin
          tick_cnt <= tick_cnt + 1'b1;
          if (tick_cnt == full_cnt) begin
            state    <= bus_monitor_pkg::RX_IDLE;
            tick_cnt <= '0;
            rx_valid <= 1'b1;
          end
        end
        default: begin
          state <= bus_monitor_pkg::RX_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Data path, LSB arrives first
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (sample_data) begin
      shift_q <= {serial_in, shift_q[7:1]};
    end
  end

  // Byte stays stable until the next frame's first data bit
  assign rx_byte = shift_q;

endmodule

// ==== source/bus_monitor_pkg.sv ====
`include "bus_monitor_macros.svh"

package bus_monitor_pkg;

  // Widths with a meaning of their own
  typedef logic [31:0]          tl_addr_t;
  typedef logic [31:0]          tl_data_t;
  typedef logic [7:0]           uart_byte_t;
  typedef logic [`COUNT_W-1:0]  event_count_t;

  // A-channel opcodes the observer cares about
  typedef enum logic [2:0] {
    PUT_FULL_DATA    = 3'd0,
    PUT_PARTIAL_DATA = 3'd1,
    GET              = 3'd4
  } tl_opcode_e;

  // Serial receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_e;

  // --------------------------------------------------
  // Observed channels, only the fields that are used
  // --------------------------------------------------
  typedef struct packed {
    logic       a_valid;
    logic       a_ready;
    tl_opcode_e a_opcode;
    tl_addr_t   a_address;
    tl_data_t   a_data;
  } tl_req_obs_t;

  typedef struct packed {
    logic d_valid;
    logic d_error;
  } tl_rsp_obs_t;

endpackage

// ==== source/bus_monitor_macros.svh ====
`ifndef BUS_MONITOR_MACROS_SVH
`define BUS_MONITOR_MACROS_SVH

// --------------------------------------------------
// UART register map as seen on the TL-UL bus
// --------------------------------------------------
`define UART_BASE      32'h0003_0000
`define UART_CTRL_OFF  32'h10
`define UART_WDATA_OFF 32'h1c

// --------------------------------------------------
// Serial line timing and statistics width
// --------------------------------------------------
// Roughly 115200 baud from a 10 MHz clock
`define UART_BIT_TICKS 87

`define COUNT_W 16

`endif
